/* src/prep_cfg_pkg.sv */
`default_nettype none

package prep_cfg_pkg;

  ////////////////////////////////////////
  // Arithmetic and field widths
  ////////////////////////////////////////
  localparam int SAMPLE_W   = 16;                   // One I or Q part
  localparam int GAIN_W     = 16;                   // Unsigned Q8.8
  localparam int GAIN_SHIFT = 8;                    // Drops the fraction bits of the gain
  localparam int DIFF_W     = SAMPLE_W + 1;         // Sample minus offset, no overflow
  localparam int PROD_W     = DIFF_W + GAIN_W + 1;  // Signed diff times unsigned gain
  localparam int CNT_W      = 16;                   // Word counts
  localparam int MEM_ADDR_W = 18;                   // Memory port and base address fields

  localparam logic [GAIN_W-1:0] GAIN_UNITY = 16'h0100;  // 1.0

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////
  localparam int          REG_ADDR_W = 4;
  localparam logic [31:0] REG_ID_VAL = 32'h0000_6666;

  typedef enum logic [REG_ADDR_W-1:0] {
    REG_DATA_NUM = 4'd0,
    REG_RD_BASE  = 4'd1,
    REG_WR_BASE  = 4'd2,
    REG_DC_U     = 4'd3,  // I upper half, Q lower half
    REG_GAIN     = 4'd4,
    REG_ID       = 4'd5   // Read only
  } reg_addr_e;

  // Settings of one pass
  typedef struct packed {
    logic [CNT_W-1:0]      data_num;
    logic [MEM_ADDR_W-1:0] rd_base;
    logic [MEM_ADDR_W-1:0] wr_base;
    logic [SAMPLE_W-1:0]   dc_i;
    logic [SAMPLE_W-1:0]   dc_q;
    logic [GAIN_W-1:0]     gain;
  } prep_cfg_t;

endpackage

`default_nettype wire

/* src/prep_ctrl_pkg.sv */
`default_nettype none

package prep_ctrl_pkg;

  ////////////////////////////////////////
  // Memory port widths
  ////////////////////////////////////////
  localparam int MEM_DATA_W = 32;              // {I, Q}
  localparam int MEM_STRB_W = MEM_DATA_W / 8;  // Byte enables

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,
    WAIT_FOR_TRIG,
    MEM_REQ,
    PE_PROC,
    MEM_REL,
    DONE_REQ
  } ctrl_state_e;

  // Reported with o_finish
  typedef struct packed {
    logic                             aborted;
    logic [prep_cfg_pkg::CNT_W-1:0]   words_written;
  } finish_info_t;

  ////////////////////////////////////////
  // Memory ports
  ////////////////////////////////////////
  // Read port of input memory A, data back one cycle later
  typedef struct packed {
    logic                                en;
    logic [prep_cfg_pkg::MEM_ADDR_W-1:0] addr;
  } mem_rd_t;

  // Write port of output memory A
  typedef struct packed {
    logic                                en;
    logic [prep_cfg_pkg::MEM_ADDR_W-1:0] addr;
    logic [MEM_DATA_W-1:0]               data;
    logic [MEM_STRB_W-1:0]               strb;
  } mem_wr_t;

endpackage

`default_nettype wire

/* src/prep_regs.sv */
`default_nettype none

module prep_regs #(
  parameter int ADDR_W = 18
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_reg_wr,
  input  logic                      i_reg_rd,
  input  prep_cfg_pkg::reg_addr_e   i_reg_addr,
  input  logic [31:0]               i_reg_wdata,
  output logic [31:0]               o_reg_rdata,
  output prep_cfg_pkg::prep_cfg_t   o_cfg
);

  import prep_cfg_pkg::*;

  logic [31:0] rdata_nxt;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_cfg <= '{gain: GAIN_UNITY, default: '0};  // Unity gain, no offset
    end else if (i_reg_wr) begin
      case (i_reg_addr)
        REG_DATA_NUM: o_cfg.data_num <= i_reg_wdata[CNT_W-1:0];
        REG_RD_BASE:  o_cfg.rd_base  <= MEM_ADDR_W'(i_reg_wdata[ADDR_W-1:0]);
        REG_WR_BASE:  o_cfg.wr_base  <= MEM_ADDR_W'(i_reg_wdata[ADDR_W-1:0]);
        REG_DC_U: begin
          o_cfg.dc_i <= i_reg_wdata[2*SAMPLE_W-1:SAMPLE_W];
          o_cfg.dc_q <= i_reg_wdata[SAMPLE_W-1:0];
        end
        REG_GAIN:     o_cfg.gain     <= i_reg_wdata[GAIN_W-1:0];
        default: ;  // ID and holes ignore writes
      endcase
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////
  always_comb begin
    case (i_reg_addr)
      REG_DATA_NUM: rdata_nxt = 32'(o_cfg.data_num);
      REG_RD_BASE:  rdata_nxt = 32'(o_cfg.rd_base);
      REG_WR_BASE:  rdata_nxt = 32'(o_cfg.wr_base);
      REG_DC_U:     rdata_nxt = {o_cfg.dc_i, o_cfg.dc_q};
      REG_GAIN:     rdata_nxt = 32'(o_cfg.gain);
      REG_ID:       rdata_nxt = REG_ID_VAL;
      default:      rdata_nxt = '0;  // Unmapped
    endcase
  end

  // Read data one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_reg_rdata <= '0;
    end else if (i_reg_rd) begin
      o_reg_rdata <= rdata_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/prep_ctrl_fsm.sv */
`default_nettype none

module prep_ctrl_fsm (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_cmd_valid,
  input  logic                               i_start,
  input  logic                               i_stop,
  input  logic                               i_mem_ack,
  input  logic                               i_finish_ack,
  input  logic                               i_pe_done,
  input  logic [prep_cfg_pkg::CNT_W-1:0]     i_words_written,
  output logic                               o_cmd_ack,
  output logic                               o_start_ack,
  output logic                               o_mem_req,
  output logic                               o_finish,
  output prep_ctrl_pkg::finish_info_t        o_finish_info,
  output logic                               o_pe_start,
  output logic                               o_pe_abort
);

  import prep_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        pe_busy;   // Engine has samples left to write

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:          if (i_cmd_valid) state_nxt = WAIT_FOR_TRIG;
      WAIT_FOR_TRIG: begin
        if (i_stop) begin
          state_nxt = DONE_REQ;  // Abort before any memory traffic
        end else if (i_start) begin
          state_nxt = MEM_REQ;
        end
      end
      MEM_REQ:       if (i_mem_ack) state_nxt = PE_PROC;
      PE_PROC:       if (i_pe_done || i_stop) state_nxt = MEM_REL;
      // Banks released and in-flight writes drained
      MEM_REL:       if (!i_mem_ack && !pe_busy) state_nxt = DONE_REQ;
      DONE_REQ:      if (i_finish_ack) state_nxt = IDLE;
      default:       state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_cmd_ack     <= 1'b0;
      o_start_ack   <= 1'b0;
      o_mem_req     <= 1'b0;
      o_finish      <= 1'b0;
      o_finish_info <= '0;
      o_pe_start    <= 1'b0;
      o_pe_abort    <= 1'b0;
      pe_busy       <= 1'b0;
    end else begin
      o_cmd_ack   <= 1'b0;  // Pulses unless set below
      o_start_ack <= 1'b0;
      o_pe_start  <= 1'b0;
      case (state)
        IDLE: o_cmd_ack <= i_cmd_valid;
        WAIT_FOR_TRIG: begin
          if (i_stop) begin
            o_finish      <= 1'b1;
            o_finish_info <= '{aborted: 1'b1, words_written: '0};
          end else if (i_start) begin
            o_start_ack <= 1'b1;
            o_mem_req   <= 1'b1;
          end
        end
        MEM_REQ: begin
          if (i_mem_ack) begin
            o_mem_req  <= 1'b0;
            o_pe_start <= 1'b1;  // Same cycle as the request drop
            pe_busy    <= 1'b1;
          end
        end
        PE_PROC: if (i_stop) o_pe_abort <= 1'b1;
        MEM_REL: begin
          if (!i_mem_ack && !pe_busy) begin
            o_finish      <= 1'b1;
            o_finish_info <= '{aborted: o_pe_abort, words_written: i_words_written};
          end
        end
        DONE_REQ: begin
          if (i_finish_ack) begin
            o_finish      <= 1'b0;
            o_finish_info <= '0;
            o_pe_abort    <= 1'b0;
          end
        end
        default: ;
      endcase
      if (i_pe_done) pe_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/prep_pe.sv */
`default_nettype none

module prep_pe #(
  parameter int ADDR_W = 18
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  prep_cfg_pkg::prep_cfg_t                 i_cfg,
  input  logic                                    i_start,
  input  logic                                    i_abort,
  input  logic [prep_ctrl_pkg::MEM_DATA_W-1:0]    i_m0_rd_data,
  output prep_ctrl_pkg::mem_rd_t                  o_m0_rd,
  output prep_ctrl_pkg::mem_wr_t                  o_m1_wr,
  output logic                                    o_done,
  output logic [prep_cfg_pkg::CNT_W-1:0]          o_words_written
);

  import prep_cfg_pkg::*;
  import prep_ctrl_pkg::*;

  // Read side
  logic                       rd_en;
  logic [ADDR_W-1:0]          rd_addr;
  logic [CNT_W-1:0]           rd_left;   // Reads after the current one

  // Stage valids
  logic                       ret_vld;   // Data back from memory
  logic                       sub_vld;   // Offset removed
  logic                       wr_en;     // Scaled word on the write port

  logic signed [SAMPLE_W-1:0] smp_i;
  logic signed [SAMPLE_W-1:0] smp_q;
  logic signed [DIFF_W-1:0]   sub_i;
  logic signed [DIFF_W-1:0]   sub_q;
  logic [ADDR_W-1:0]          wr_ptr;
  logic [ADDR_W-1:0]          wr_addr;
  logic [MEM_DATA_W-1:0]      wr_data;

  // Multiply by Q8.8 gain, shift, clamp to the signed sample range
  function automatic logic [SAMPLE_W-1:0] scale_sat(
    input logic signed [DIFF_W-1:0] diff,
    input logic        [GAIN_W-1:0] gain
  );
    logic signed [PROD_W-1:0] prod;
    logic                     ovf_pos;
    logic                     ovf_neg;
    prod    = (diff * $signed({1'b0, gain})) >>> GAIN_SHIFT;
    ovf_pos = !prod[PROD_W-1] && (|prod[PROD_W-2:SAMPLE_W-1]);
    ovf_neg = prod[PROD_W-1] && !(&prod[PROD_W-2:SAMPLE_W-1]);
    if (ovf_pos) begin
      return {1'b0, {(SAMPLE_W-1){1'b1}}};
    end else if (ovf_neg) begin
      return {1'b1, {(SAMPLE_W-1){1'b0}}};
    end
    return prod[SAMPLE_W-1:0];
  endfunction

  assign smp_i = i_m0_rd_data[2*SAMPLE_W-1:SAMPLE_W];
  assign smp_q = i_m0_rd_data[SAMPLE_W-1:0];

  ////////////////////////////////////////
  // Read counter and stage valids
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en           <= 1'b0;
      rd_left         <= '0;
      ret_vld         <= 1'b0;
      sub_vld         <= 1'b0;
      wr_en           <= 1'b0;
      o_done          <= 1'b0;
      o_words_written <= '0;
    end else begin
      ret_vld <= rd_en;
      sub_vld <= ret_vld;
      wr_en   <= sub_vld;
      // Last sample about to be written, or an empty pass
      o_done  <= (sub_vld && !ret_vld && !rd_en) || (i_start && i_cfg.data_num == '0);
      if (i_start) begin
        rd_en           <= (i_cfg.data_num != '0);
        rd_left         <= i_cfg.data_num - 1'b1;
        o_words_written <= '0;
      end else begin
        if (rd_en && (i_abort || rd_left == '0)) begin
          rd_en <= 1'b0;  // Samples in flight still drain
        end else if (rd_en) begin
          rd_left <= rd_left - 1'b1;
        end
        if (sub_vld) o_words_written <= o_words_written + 1'b1;  // Counts with the write
      end
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_start) begin
      rd_addr <= i_cfg.rd_base[ADDR_W-1:0];
      wr_ptr  <= i_cfg.wr_base[ADDR_W-1:0];
    end else begin
      if (rd_en)   rd_addr <= rd_addr + 1'b1;
      if (sub_vld) wr_ptr  <= wr_ptr + 1'b1;
    end
    if (ret_vld) begin
      sub_i <= smp_i - $signed(i_cfg.dc_i);
      sub_q <= smp_q - $signed(i_cfg.dc_q);
    end
    if (sub_vld) begin
      wr_addr <= wr_ptr;
      wr_data <= {scale_sat(sub_i, i_cfg.gain), scale_sat(sub_q, i_cfg.gain)};
    end
  end

  assign o_m0_rd = '{en: rd_en, addr: MEM_ADDR_W'(rd_addr)};
  assign o_m1_wr = '{en:   wr_en,
                     addr: MEM_ADDR_W'(wr_addr),
                     data: wr_data,
                     strb: {MEM_STRB_W{1'b1}}};

endmodule

`default_nettype wire

/* src/rsp_s1_prep.sv */
`default_nettype none

module rsp_s1_prep #(
  parameter int ADDR_W = 18
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // Register port
  input  logic                                    i_reg_wr,
  input  logic                                    i_reg_rd,
  input  prep_cfg_pkg::reg_addr_e                 i_reg_addr,
  input  logic [31:0]                             i_reg_wdata,
  output logic [31:0]                             o_reg_rdata,
  // Control
  input  logic                                    i_cmd_valid,
  input  logic                                    i_start,
  input  logic                                    i_stop,
  input  logic                                    i_mem_ack,
  input  logic                                    i_finish_ack,
  output logic                                    o_cmd_ack,
  output logic                                    o_start_ack,
  output logic                                    o_mem_req,
  output logic                                    o_finish,
  output prep_ctrl_pkg::finish_info_t             o_finish_info,
  // Memory A ports
  input  logic [prep_ctrl_pkg::MEM_DATA_W-1:0]    i_m0_rd_data,
  output prep_ctrl_pkg::mem_rd_t                  o_m0_rd,
  output prep_ctrl_pkg::mem_wr_t                  o_m1_wr
);

  import prep_cfg_pkg::*;

  prep_cfg_t        cfg;
  logic             pe_start;
  logic             pe_abort;
  logic             pe_done;
  logic [CNT_W-1:0] words_written;

  ////////////////////////////////////////
  // Run settings
  ////////////////////////////////////////
  prep_regs #(
    .ADDR_W (ADDR_W)
  ) prep_regs_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_reg_wr    (i_reg_wr),
    .i_reg_rd    (i_reg_rd),
    .i_reg_addr  (i_reg_addr),
    .i_reg_wdata (i_reg_wdata),
    .o_reg_rdata (o_reg_rdata),
    .o_cfg       (cfg)
  );

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////
  prep_ctrl_fsm prep_ctrl_fsm_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_cmd_valid     (i_cmd_valid),
    .i_start         (i_start),
    .i_stop          (i_stop),
    .i_mem_ack       (i_mem_ack),
    .i_finish_ack    (i_finish_ack),
    .i_pe_done       (pe_done),
    .i_words_written (words_written),
    .o_cmd_ack       (o_cmd_ack),
    .o_start_ack     (o_start_ack),
    .o_mem_req       (o_mem_req),
    .o_finish        (o_finish),
    .o_finish_info   (o_finish_info),
    .o_pe_start      (pe_start),
    .o_pe_abort      (pe_abort)
  );

  ////////////////////////////////////////
  // DC removal and gain engine
  ////////////////////////////////////////
  prep_pe #(
    .ADDR_W (ADDR_W)
  ) prep_pe_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_cfg           (cfg),
    .i_start         (pe_start),
    .i_abort         (pe_abort),
    .i_m0_rd_data    (i_m0_rd_data),
    .o_m0_rd         (o_m0_rd),
    .o_m1_wr         (o_m1_wr),
    .o_done          (pe_done),
    .o_words_written (words_written)
  );

endmodule

`default_nettype wire

/* verif/prep_assert.sv */
`default_nettype none

module prep_assert (
  input logic clk,
  input logic rst_n,
  input logic i_cmd_ack,
  input logic i_start_ack,
  input logic i_mem_req,
  input logic i_finish,
  input logic i_finish_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // Sequencer handshakes
  ////////////////////////////////////////
  cmd_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    i_cmd_ack |=> !i_cmd_ack)
    else $error("o_cmd_ack high for more than one cycle");

  start_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    i_start_ack |=> !i_start_ack)
    else $error("o_start_ack high for more than one cycle");

  // Finish held until acknowledged
  finish_held: assert property (@(posedge clk) disable iff (!rst_n)
    i_finish && !i_finish_ack |=> i_finish)
    else $error("o_finish dropped without i_finish_ack");

  req_quiet_in_finish: assert property (@(posedge clk) disable iff (!rst_n)
    i_finish |-> !$rose(i_mem_req))
    else $error("o_mem_req rose while o_finish was high");

endmodule

bind prep_ctrl_fsm prep_assert prep_assert_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .i_cmd_ack    (o_cmd_ack),
  .i_start_ack  (o_start_ack),
  .i_mem_req    (o_mem_req),
  .i_finish     (o_finish),
  .i_finish_ack (i_finish_ack)
);

`default_nettype wire

/* verif/tb_rsp_s1_prep.sv */
`default_nettype none

module tb_rsp_s1_prep;

  timeunit 1ns;
  timeprecision 1ps;

  import prep_cfg_pkg::*;
  import prep_ctrl_pkg::*;

  localparam int ADDR_W    = 18;
  localparam int MEM_AW    = 10;             // Model depth, well below the DUT address space
  localparam int MEM_WORDS = 1 << MEM_AW;
  localparam int TIMEOUT   = 2000;           // Cycles per wait loop

  logic         clk;
  logic         rst_n;
  logic         i_reg_wr;
  logic         i_reg_rd;
  reg_addr_e    i_reg_addr;
  logic [31:0]  i_reg_wdata;
  logic [31:0]  o_reg_rdata;
  logic         i_cmd_valid;
  logic         i_start;
  logic         i_stop;
  logic         i_mem_ack;
  logic         i_finish_ack;
  logic         o_cmd_ack;
  logic         o_start_ack;
  logic         o_mem_req;
  logic         o_finish;
  finish_info_t o_finish_info;
  logic [31:0]  i_m0_rd_data;
  mem_rd_t      o_m0_rd;
  mem_wr_t      o_m1_wr;

  logic [31:0]           mem_in  [MEM_WORDS];  // Input memory A
  logic [31:0]           mem_out [MEM_WORDS];  // Output memory A
  int                    wr_count;
  logic                  req_seen;
  logic                  rd_pend;
  logic [MEM_ADDR_W-1:0] rd_addr_q;
  integer                seed;

  rsp_s1_prep #(
    .ADDR_W (ADDR_W)
  ) rsp_s1_prep_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_reg_wr      (i_reg_wr),
    .i_reg_rd      (i_reg_rd),
    .i_reg_addr    (i_reg_addr),
    .i_reg_wdata   (i_reg_wdata),
    .o_reg_rdata   (o_reg_rdata),
    .i_cmd_valid   (i_cmd_valid),
    .i_start       (i_start),
    .i_stop        (i_stop),
    .i_mem_ack     (i_mem_ack),
    .i_finish_ack  (i_finish_ack),
    .o_cmd_ack     (o_cmd_ack),
    .o_start_ack   (o_start_ack),
    .o_mem_req     (o_mem_req),
    .o_finish      (o_finish),
    .o_finish_info (o_finish_info),
    .i_m0_rd_data  (i_m0_rd_data),
    .o_m0_rd       (o_m0_rd),
    .o_m1_wr       (o_m1_wr)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  // Reference model of one part: subtract, scale by Q8.8, clamp
  function automatic logic [15:0] expect_part(input logic [15:0] smp, input logic [15:0] dc,
                                              input logic [15:0] gain);
    longint diff;
    longint scaled;
    diff   = longint'($signed(smp)) - longint'($signed(dc));
    scaled = (diff * longint'(gain)) >>> GAIN_SHIFT;
    if (scaled > 32767) return 16'h7FFF;
    if (scaled < -32768) return 16'h8000;
    return scaled[15:0];
  endfunction

  function automatic logic [31:0] expect_word(input logic [31:0] smp, input logic [31:0] dc,
                                              input logic [15:0] gain);
    return {expect_part(smp[31:16], dc[31:16], gain), expect_part(smp[15:0], dc[15:0], gain)};
  endfunction

  ////////////////////////////////////////
  // Memory models and bus monitor
  ////////////////////////////////////////
  // Request seen before the edge, data back one cycle later
  always @(negedge clk) begin
    rd_pend   = rst_n && o_m0_rd.en;
    rd_addr_q = o_m0_rd.addr;
    if (rd_pend && rd_addr_q[MEM_ADDR_W-1:MEM_AW] != '0) abort_run("Read outside input memory");
    @(posedge clk);
    #1;
    if (rd_pend) i_m0_rd_data = mem_in[rd_addr_q[MEM_AW-1:0]];
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (o_mem_req) req_seen = 1'b1;
      if (o_mem_req && (o_m0_rd.en || o_m1_wr.en)) begin
        abort_run("Memory traffic while the bank request is still pending");
      end
      if (o_m1_wr.en) begin
        check_value("o_m1_wr.strb", 32'(o_m1_wr.strb), 32'hF);
        if (o_m1_wr.addr[MEM_ADDR_W-1:MEM_AW] != '0) abort_run("Write outside output memory");
        mem_out[o_m1_wr.addr[MEM_AW-1:0]] = o_m1_wr.data;
        wr_count++;
      end
    end
  end

  task automatic clear_output();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_out[i] = 32'hBAD0_0000 | 32'(i);  // Unwritten words stay recognizable
    end
  endtask

  ////////////////////////////////////////
  // Register port
  ////////////////////////////////////////
  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    i_reg_wr    = 1'b1;
    i_reg_addr  = addr;
    i_reg_wdata = data;
    @(posedge clk);
    #1 i_reg_wr = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    i_reg_rd   = 1'b1;
    i_reg_addr = addr;
    @(posedge clk);
    #1 i_reg_rd = 1'b0;
    @(negedge clk);
    data = o_reg_rdata;
  endtask

  task automatic configure(input logic [15:0] num, input logic [31:0] rd_base,
                           input logic [31:0] wr_base, input logic [31:0] dc,
                           input logic [15:0] gain);
    reg_write(REG_DATA_NUM, 32'(num));
    reg_write(REG_RD_BASE, rd_base);
    reg_write(REG_WR_BASE, wr_base);
    reg_write(REG_DC_U, dc);
    reg_write(REG_GAIN, 32'(gain));
  endtask

  ////////////////////////////////////////
  // Sequencer phases
  ////////////////////////////////////////
  task automatic send_command();
    @(posedge clk);
    #1 i_cmd_valid = 1'b1;
    @(posedge clk);
    #1 i_cmd_valid = 1'b0;
    @(negedge clk);
    check_value("o_cmd_ack", 32'(o_cmd_ack), 32'h1);
    @(negedge clk);
    check_value("o_cmd_ack", 32'(o_cmd_ack), 32'h0);
  endtask

  task automatic send_start();
    @(posedge clk);
    #1 i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
    @(negedge clk);
    check_value("o_start_ack", 32'(o_start_ack), 32'h1);
    check_value("o_mem_req", 32'(o_mem_req), 32'h1);
    @(negedge clk);
    check_value("o_start_ack", 32'(o_start_ack), 32'h0);
    check_value("o_mem_req", 32'(o_mem_req), 32'h1);
  endtask

  // Withhold the grant, then ack until the request drops
  task automatic grant_memory(input int hold);
    repeat (hold) begin
      @(negedge clk);
      check_value("o_mem_req", 32'(o_mem_req), 32'h1);
      check_value("o_m0_rd.en", 32'(o_m0_rd.en), 32'h0);
      check_value("o_m1_wr.en", 32'(o_m1_wr.en), 32'h0);
    end
    @(posedge clk);
    #1 i_mem_ack = 1'b1;
    @(negedge clk);
    check_value("o_mem_req", 32'(o_mem_req), 32'h1);
    @(negedge clk);
    check_value("o_mem_req", 32'(o_mem_req), 32'h0);
    @(posedge clk);
    #1 i_mem_ack = 1'b0;
  endtask

  task automatic wait_finish();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("Timed out waiting for o_finish");
    end while (!o_finish);
  endtask

  task automatic wait_writes(input int target);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("Timed out waiting for output writes");
    end while (wr_count < target);
  endtask

  task automatic hold_finish(input int cycles, output finish_info_t info);
    info = o_finish_info;
    repeat (cycles) begin
      @(negedge clk);
      check_value("o_finish", 32'(o_finish), 32'h1);
      check_value("o_finish_info", 32'(o_finish_info), 32'(info));
    end
    @(posedge clk);
    #1 i_finish_ack = 1'b1;
    @(posedge clk);
    #1 i_finish_ack = 1'b0;
    @(negedge clk);
    check_value("o_finish", 32'(o_finish), 32'h0);
    check_value("o_finish_info", 32'(o_finish_info), 32'h0);
  endtask

  task automatic run_pass(input int mem_hold, input int fin_hold, output finish_info_t info);
    send_command();
    send_start();
    grant_memory(mem_hold);
    wait_finish();
    hold_finish(fin_hold, info);
  endtask

  task automatic check_block(input int rd_base, input int wr_base, input int num,
                             input logic [31:0] dc, input logic [15:0] gain);
    for (int i = 0; i < num; i++) begin
      check_value($sformatf("mem_out[0x%0h]", wr_base + i), mem_out[wr_base + i],
                  expect_word(mem_in[rd_base + i], dc, gain));
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_registers();
    logic [31:0] rdata;
    logic [31:0] amask;
    amask = (32'h1 << ADDR_W) - 32'h1;
    configure(16'h0040, 32'hFFFC_0100, 32'h0005_4321, 32'h8001_7FFE, 16'h0180);
    reg_write(REG_ID, 32'hFFFF_FFFF);  // Read only
    reg_read(REG_DATA_NUM, rdata);
    check_value("o_reg_rdata DATA_NUM", rdata, 32'h0000_0040);
    reg_read(REG_RD_BASE, rdata);
    check_value("o_reg_rdata RD_BASE", rdata, 32'hFFFC_0100 & amask);
    reg_read(REG_WR_BASE, rdata);
    check_value("o_reg_rdata WR_BASE", rdata, 32'h0005_4321 & amask);
    reg_read(REG_DC_U, rdata);
    check_value("o_reg_rdata DC_U", rdata, 32'h8001_7FFE);
    reg_read(REG_GAIN, rdata);
    check_value("o_reg_rdata GAIN", rdata, 32'h0000_0180);
    reg_read(REG_ID, rdata);
    check_value("o_reg_rdata ID", rdata, 32'h0000_6666);
    reg_read(reg_addr_e'(4'd9), rdata);
    check_value("o_reg_rdata unmapped", rdata, 32'h0);
  endtask

  task automatic test_full_run();
    finish_info_t info;
    int           base;
    configure(16'd64, 32'h100, 32'h200, {16'h012C, 16'hFF38}, 16'h0180);  // 1.5
    clear_output();
    base = wr_count;
    run_pass(2, 1, info);
    check_value("o_finish_info.aborted", 32'(info.aborted), 32'h0);
    check_value("o_finish_info.words_written", 32'(info.words_written), 32'd64);
    check_value("write count", 32'(wr_count - base), 32'd64);
    check_block(32'h100, 32'h200, 64, {16'h012C, 16'hFF38}, 16'h0180);
  endtask

  task automatic test_saturation();
    finish_info_t info;
    mem_in[32'h300] = {16'h7000, 16'h9000};
    mem_in[32'h301] = {16'h9000, 16'h7000};
    mem_in[32'h302] = {16'h4000, 16'hC000};
    mem_in[32'h303] = {16'h0100, 16'hFF00};  // Stays in range
    configure(16'd4, 32'h300, 32'h380, 32'h0, 16'h0400);  // 4.0
    clear_output();
    run_pass(0, 0, info);
    check_value("mem_out[0x380]", mem_out[32'h380], {16'h7FFF, 16'h8000});
    check_value("mem_out[0x381]", mem_out[32'h381], {16'h8000, 16'h7FFF});
    check_value("mem_out[0x382]", mem_out[32'h382], {16'h7FFF, 16'h8000});
    check_value("mem_out[0x383]", mem_out[32'h383], {16'h0400, 16'hFC00});
  endtask

  // Late bank grant and late finish ack
  task automatic test_handshake();
    finish_info_t info;
    configure(16'd8, 32'h140, 32'h240, 32'h0, 16'h0100);
    clear_output();
    run_pass(20, 15, info);
    check_value("o_finish_info.words_written", 32'(info.words_written), 32'd8);
    check_block(32'h140, 32'h240, 8, 32'h0, 16'h0100);
  endtask

  task automatic test_stop();
    finish_info_t info;
    int           base;
    // Stop before the trigger
    req_seen = 1'b0;
    base     = wr_count;
    send_command();
    @(posedge clk);
    #1 i_stop = 1'b1;
    @(posedge clk);
    #1 i_stop = 1'b0;
    wait_finish();
    hold_finish(2, info);
    check_value("o_finish_info.aborted", 32'(info.aborted), 32'h1);
    check_value("o_finish_info.words_written", 32'(info.words_written), 32'h0);
    check_value("o_mem_req seen", 32'(req_seen), 32'h0);
    check_value("write count", 32'(wr_count - base), 32'h0);
    // Stop in the middle of a pass
    configure(16'd64, 32'h100, 32'h280, 32'h0, 16'h0100);
    base = wr_count;
    send_command();
    send_start();
    grant_memory(0);
    wait_writes(base + 5);
    @(posedge clk);
    #1 i_stop = 1'b1;
    @(posedge clk);
    #1 i_stop = 1'b0;
    wait_finish();
    hold_finish(0, info);
    check_value("o_finish_info.aborted", 32'(info.aborted), 32'h1);
    check_value("o_finish_info.words_written", 32'(info.words_written), 32'(wr_count - base));
    if (info.words_written >= 16'd64) abort_run("Stop during a pass did not end it early");
  endtask

  initial begin
    seed         = 53;
    clk          = 1'b0;
    rst_n        = 1'b0;
    i_reg_wr     = 1'b0;
    i_reg_rd     = 1'b0;
    i_reg_addr   = REG_DATA_NUM;
    i_reg_wdata  = '0;
    i_cmd_valid  = 1'b0;
    i_start      = 1'b0;
    i_stop       = 1'b0;
    i_mem_ack    = 1'b0;
    i_finish_ack = 1'b0;
    i_m0_rd_data = '0;
    wr_count     = 0;
    req_seen     = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_in[i] = $random(seed);
    end
    clear_output();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check_value("control outputs", 32'({o_cmd_ack, o_start_ack, o_mem_req, o_finish,
                                        o_m0_rd.en, o_m1_wr.en}), 32'h0);
    check_value("o_finish_info", 32'(o_finish_info), 32'h0);
    test_registers();
    test_full_run();
    test_saturation();
    test_handshake();
    test_stop();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
src/prep_cfg_pkg.sv
src/prep_ctrl_pkg.sv
src/prep_regs.sv
src/prep_ctrl_fsm.sv
src/prep_pe.sv
src/rsp_s1_prep.sv
verif/prep_assert.sv
verif/tb_rsp_s1_prep.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rsp_s1_prep
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
